/* logo_display_top.f */
+incdir+logic
logic/logo_display_pkg.sv
logic/sprite_cfg_if.sv
logic/wb_sprite_regs.sv
logic/vga_sync_gen.sv
logic/six_logo_sprite.sv
logic/pixel_out_stage.sv
logic/logo_display_top.sv
verif/logo_display_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the logo_display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -j 0 \
   --top-module logo_display_tb \
   -Mdir obj_dir -o logo_display_sim \
   -f logo_display_top.f > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/logo_display_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
   exit 0
fi
echo "no pass line in sim.log"
exit 1

/* verif/logo_display_tb.sv */
`timescale 1ns/1ps
`include "logo_display_defines.svh"

module logo_display_tb;
   import logo_display_pkg::*;

   // ------------------------------------------------------------------------
   // frame geometry in pixel clocks
   // ------------------------------------------------------------------------
   localparam int H_TOT        = int'(`H_TOTAL);
   localparam int FRAME_CYCLES = int'(`H_TOTAL) * int'(`V_TOTAL);
   localparam int TICK_STATE   = int'(`V_DISPLAY) * int'(`H_TOTAL);
   localparam int HS_FIRST     = int'(`H_DISPLAY) + int'(`H_FRONT);
   localparam int HS_LAST      = HS_FIRST + int'(`H_SYNC) - 1;
   localparam int VS_FIRST     = int'(`V_DISPLAY) + int'(`V_FRONT);
   localparam int VS_LAST      = VS_FIRST + int'(`V_SYNC) - 1;
   localparam int CLK_PERIOD   = 4;
   localparam int ACK_LIMIT    = 16;
   localparam int NUM_STEPS    = 7;
   localparam logic [1:0] BOX    = 2'd0;
   localparam logic [1:0] RANDOM = 2'd1;
   localparam logic [1:0] SYNC   = 2'd2;

   typedef struct packed {
      logic [9:0] x;
      logic [9:0] y;
      logic [2:0] rgb;
      logic       en;
   } sprite_cfg_t;

   // one table row with writes, read-back, probed frame and probe kind
   typedef struct packed {
      logic        do_pos;
      logic [31:0] pos_word;
      logic        do_style;
      logic [31:0] style_word;
      logic        do_read;
      logic [7:0]  frame;
      logic [1:0]  kind;
   } step_t;

   logic        clk;
   logic        reset;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic        wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   rgb_t        vga_rgb;
   logic        vga_hsync;
   logic        vga_vsync;

   step_t       steps [NUM_STEPS];
   string       step_names [NUM_STEPS];
   logic        table_ready;
   logic [31:0] glyph [16];
   logic [2:0]  frame_buf [0:640*480-1];
   int          probe_x[$];
   int          probe_y[$];
   int          cyc_cnt;
   int          cap_frame;
   logic        sync_on;
   int          seed;
   int          errors;
   int          checks;
   int          mon_t;
   int          mon_x;
   int          mon_y;

   // register model where old_cfg holds until eff_frame and new_cfg tracks the shadow
   sprite_cfg_t old_cfg;
   sprite_cfg_t new_cfg;
   int          eff_frame;

   logo_display_top UUT (
      .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .vga_rgb(vga_rgb), .vga_hsync(vga_hsync), .vga_vsync(vga_vsync)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // posedges since reset release so the output shows state cyc_cnt - 1
   always @(posedge clk or posedge reset)
   begin
      if (reset)
         cyc_cnt <= 0;
      else
         cyc_cnt <= cyc_cnt + 1;
   end

   task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
      checks++;
      if (got !== expected)
      begin
         errors++;
         $display("CHECK FAILED at time %0t: %s, got %0h expected %0h", $time, what, got,
                  expected);
      end
   endtask

   // ------------------------------------------------------------------------
   // capture of the probed frame with sync levels checked on the fly
   // ------------------------------------------------------------------------
   always @(negedge clk)
   begin
      if (!reset && cyc_cnt >= 1)
      begin
         mon_t = cyc_cnt - 1;
         mon_x = mon_t % H_TOT;
         mon_y = (mon_t % FRAME_CYCLES) / H_TOT;
         if (mon_t / FRAME_CYCLES == cap_frame)
         begin
            if (mon_x < 640 && mon_y < 480)
               frame_buf[mon_y * 640 + mon_x] = vga_rgb;
            if (sync_on)
            begin
               check_value(vga_hsync, !(mon_x >= HS_FIRST && mon_x <= HS_LAST), "hsync level");
               check_value(vga_vsync, !(mon_y >= VS_FIRST && mon_y <= VS_LAST), "vsync level");
            end
         end
      end
   end

   // master holds the request until ack and is called on a falling edge
   task automatic bus_access(input logic we, input logic adr, input logic [31:0] data,
                             output logic [31:0] rdata);
      int waited;
      waited = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = data;
      @(negedge clk);
      while (wb_ack !== 1'b1 && waited < ACK_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (wb_ack !== 1'b1)
      begin
         errors++;
         $display("wishbone access to register %0d was never acknowledged", adr);
      end
      rdata  = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   function automatic sprite_cfg_t cfg_for_frame(input int f);
      return (f >= eff_frame) ? new_cfg : old_cfg;
   endfunction

   // bit index is the column with bit 0 at the left edge of the box
   function automatic logic [2:0] expected_pixel(input sprite_cfg_t c, input int x, input int y);
      int dx;
      int dy;
      dx = x - int'(c.x);
      dy = y - int'(c.y);
      if (!c.en || dx < 0 || dx >= 32 || dy < 0 || dy >= 16)
         return 3'b000;
      return glyph[dy][dx] ? c.rgb : 3'b000;
   endfunction

   task automatic add_box_probes(input sprite_cfg_t c);
      int x;
      int y;
      // whole box plus a two pixel ring
      for (y = int'(c.y) - 2; y <= int'(c.y) + 17; y++)
         for (x = int'(c.x) - 2; x <= int'(c.x) + 33; x++)
            if (x >= 0 && x < 640 && y >= 0 && y < 480)
            begin
               probe_x.push_back(x);
               probe_y.push_back(y);
            end
   endtask

   task automatic add_random_probes(input sprite_cfg_t c);
      int n;
      int x;
      int y;
      for (n = 0; n < 64; n++)
      begin
         x = int'(c.x) - 8 + int'({$random(seed)} % 48);
         y = int'(c.y) - 4 + int'({$random(seed)} % 24);
         probe_x.push_back((x < 0) ? 0 : ((x > 639) ? 639 : x));
         probe_y.push_back((y < 0) ? 0 : ((y > 479) ? 479 : y));
      end
   endtask

   task automatic fill_table();
      glyph = '{32'h000F_F000, 32'h003F_F800, 32'h007F_FC00, 32'h00FC_7E00,
                32'h01F8_3F00, 32'h01F0_1F00, 32'h03F0_0000, 32'h03F0_0000,
                32'h03E7_F000, 32'h03FF_FE00, 32'h03F8_3F00, 32'h03F0_3F00,
                32'h01F8_3F00, 32'h01FC_7F00, 32'h003F_F800, 32'h001F_F000};
      steps[0] = '{1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 8'd0, BOX};
      step_names[0] = "reset_view";
      // x 100 and y 200 with every reserved bit set
      steps[1] = '{1'b1, 32'hfcc8_fc64, 1'b0, 32'h0, 1'b1, 8'd0, BOX};
      step_names[1] = "readback_hold";
      steps[2] = '{1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 8'd1, BOX};
      step_names[2] = "position_moved";
      steps[3] = '{1'b0, 32'h0, 1'b1, 32'h0000_0102, 1'b1, 8'd2, BOX};
      step_names[3] = "new_colour";
      steps[4] = '{1'b0, 32'h0, 1'b1, 32'h0000_0007, 1'b0, 8'd3, BOX};
      step_names[4] = "disabled";
      steps[5] = '{1'b0, 32'h0, 1'b1, 32'h0000_0103, 1'b0, 8'd4, SYNC};
      step_names[5] = "sync_timing";
      steps[6] = '{1'b1, 32'h0028_0014, 1'b0, 32'h0, 1'b0, 8'd6, RANDOM};
      step_names[6] = "random_pixels";
   endtask

   // ------------------------------------------------------------------------
   // one table row
   // ------------------------------------------------------------------------
   task automatic run_step(input int i);
      step_t       s;
      sprite_cfg_t c;
      logic [31:0] rd;
      int          err0;
      int          chk0;
      int          t_now;
      int          last;
      s = steps[i];
      err0 = errors;
      chk0 = checks;
      if (cap_frame != int'(s.frame) && cyc_cnt > int'(s.frame) * FRAME_CYCLES)
      begin
         errors++;
         $display("step %0d: frame %0d had already started", i, s.frame);
      end
      cap_frame = s.frame;
      sync_on = (s.kind == SYNC);
      t_now = (cyc_cnt > 0) ? cyc_cnt - 1 : 0;
      if (s.do_pos || s.do_style)
         old_cfg = cfg_for_frame(t_now / FRAME_CYCLES);
      if (s.do_pos)
      begin
         bus_access(1'b1, 1'b0, s.pos_word, rd);
         new_cfg.x = s.pos_word[9:0];
         new_cfg.y = s.pos_word[25:16];
      end
      if (s.do_style)
      begin
         bus_access(1'b1, 1'b1, s.style_word, rd);
         new_cfg.rgb = s.style_word[2:0];
         new_cfg.en  = s.style_word[8];
      end
      // shadow goes live at the next start of vertical blanking
      if (s.do_pos || s.do_style)
      begin
         t_now = cyc_cnt - 1;
         eff_frame = t_now / FRAME_CYCLES + ((t_now % FRAME_CYCLES < TICK_STATE) ? 1 : 2);
      end
      if (s.do_read)
      begin
         bus_access(1'b0, 1'b0, 32'h0, rd);
         check_value(rd, {6'd0, new_cfg.y, 6'd0, new_cfg.x}, "position read-back");
         bus_access(1'b0, 1'b1, 32'h0, rd);
         check_value(rd, {23'd0, new_cfg.en, 5'd0, new_cfg.rgb}, "style read-back");
      end
      c = cfg_for_frame(s.frame);
      if (s.kind == SYNC)
      begin
         while (cyc_cnt <= (int'(s.frame) + 1) * FRAME_CYCLES)
            @(negedge clk);
         sync_on = 1'b0;
      end
      else
      begin
         probe_x.delete();
         probe_y.delete();
         if (s.kind == BOX)
         begin
            add_box_probes(old_cfg);
            add_box_probes(new_cfg);
         end
         else
            add_random_probes(c);
         last = 0;
         foreach (probe_x[k])
            if (int'(s.frame) * FRAME_CYCLES + H_TOT * probe_y[k] + probe_x[k] + 1 > last)
               last = int'(s.frame) * FRAME_CYCLES + H_TOT * probe_y[k] + probe_x[k] + 1;
         while (cyc_cnt <= last)
            @(negedge clk);
         foreach (probe_x[k])
            check_value(frame_buf[probe_y[k] * 640 + probe_x[k]],
                        expected_pixel(c, probe_x[k], probe_y[k]),
                        $sformatf("pixel (%0d,%0d) of frame %0d", probe_x[k], probe_y[k],
                                  s.frame));
      end
      $display("step %0d %s: %s, %0d checks, %0d errors", i, step_names[i],
               (errors == err0) ? "ok" : "failed", checks - chk0, errors - err0);
   endtask

   // run limit from the frames the table covers plus two
   initial
   begin
      longint frames;
      int     n;
      frames = 0;
      wait (table_ready === 1'b1);
      for (n = 0; n < NUM_STEPS; n++)
         if (longint'(steps[n].frame) + 1 > frames)
            frames = longint'(steps[n].frame) + 1;
      #((frames + 2) * FRAME_CYCLES * CLK_PERIOD);
      $display("timeout: the run did not finish within %0d frames", frames + 2);
      $display("TEST FAIL");
      $finish;
   end

   initial
   begin
      int i;
      clk         = 1'b0;
      reset       = 1'b1;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = 1'b0;
      wb_dat_w    = 32'h0;
      cap_frame   = 0;
      sync_on     = 1'b0;
      seed        = 32'hb6d6_858b;
      errors      = 0;
      checks      = 0;
      old_cfg     = '{`POS_X_RESET, `POS_Y_RESET, `STYLE_RGB_RESET, `STYLE_EN_RESET};
      new_cfg     = old_cfg;
      eff_frame   = 0;
      table_ready = 1'b0;
      fill_table();
      table_ready = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      for (i = 0; i < NUM_STEPS; i++)
         run_step(i);
      $display("summary: %0d steps, %0d checks, %0d errors", NUM_STEPS, checks, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

/* logic/logo_display_top.sv */
`timescale 1ns/1ps

module logo_display_top (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  logic                  wb_adr,
   input  logic [31:0]           wb_dat_w,
   output logic [31:0]           wb_dat_r,
   output logic                  wb_ack,
   output logo_display_pkg::rgb_t vga_rgb,
   output logic                  vga_hsync,
   output logic                  vga_vsync
);
   import logo_display_pkg::*;

   // timing to sprite and output
   pix_coord_t pix_x;
   pix_coord_t pix_y;
   logic       hsync;
   logic       vsync;
   logic       video_on;
   logic       refr_tick;
   logic       sprite_on;

   // active sprite setup
   sprite_cfg_if cfg_bus ();

   // --------------------------------------------------------------------------
   // host side
   // --------------------------------------------------------------------------
   wb_sprite_regs u_regs (
      .clk       (clk),
      .reset     (reset),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .refr_tick (refr_tick),
      .cfg       (cfg_bus.source)
   );

   // --------------------------------------------------------------------------
   // video path
   // --------------------------------------------------------------------------
   vga_sync_gen u_sync (
      .clk       (clk),
      .reset     (reset),
      .pix_x     (pix_x),
      .pix_y     (pix_y),
      .hsync     (hsync),
      .vsync     (vsync),
      .video_on  (video_on),
      .refr_tick (refr_tick)
   );

   six_logo_sprite u_sprite (
      .pix_x     (pix_x),
      .pix_y     (pix_y),
      .video_on  (video_on),
      .cfg       (cfg_bus.sink),
      .sprite_on (sprite_on)
   );

   // colour taken straight from the active setup
   pixel_out_stage u_out (
      .clk        (clk),
      .reset      (reset),
      .sprite_on  (sprite_on),
      .hsync_in   (hsync),
      .vsync_in   (vsync),
      .sprite_rgb (cfg_bus.rgb),
      .vga_rgb    (vga_rgb),
      .vga_hsync  (vga_hsync),
      .vga_vsync  (vga_vsync)
   );

endmodule

/* logic/pixel_out_stage.sv */
`timescale 1ns/1ps

module pixel_out_stage (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  sprite_on,
   input  logic                  hsync_in,
   input  logic                  vsync_in,
   input  logo_display_pkg::rgb_t sprite_rgb,
   output logo_display_pkg::rgb_t vga_rgb,
   output logic                  vga_hsync,
   output logic                  vga_vsync
);
   import logo_display_pkg::*;

   // black background
   rgb_t rgb_next;

   assign rgb_next = sprite_on ? sprite_rgb : 3'b000;

   // --------------------------------------------------------------------------
   // output register
   // --------------------------------------------------------------------------
   // colour and syncs share one stage to stay aligned
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         vga_rgb   <= 3'b000;
         // syncs idle high
         vga_hsync <= 1'b1;
         vga_vsync <= 1'b1;
      end
      else
      begin
         vga_rgb   <= rgb_next;
         vga_hsync <= hsync_in;
         vga_vsync <= vsync_in;
      end
   end

endmodule

/* logic/six_logo_sprite.sv */
`timescale 1ns/1ps
`include "logo_display_defines.svh"

module six_logo_sprite (
   input  logo_display_pkg::pix_coord_t pix_x,
   input  logo_display_pkg::pix_coord_t pix_y,
   input  logic                        video_on,
   sprite_cfg_if.sink                  cfg,
   output logic                        sprite_on
);
   import logo_display_pkg::*;

   // offsets inside the box
   pix_coord_t  dx;
   pix_coord_t  dy;
   logic        in_x;
   logic        in_y;

   logic [3:0]  rom_row;
   logic [4:0]  rom_col;
   logic [31:0] rom_data;
   logic        rom_bit;

   // --------------------------------------------------------------------------
   // glyph rom, one word per row
   // --------------------------------------------------------------------------
   // bit index is the column, so bit 0 sits at the left edge
   always_comb
   begin
      rom_data = '0;
      case (rom_row)
         4'h0: rom_data = 32'b0000_0000_0000_1111_1111_0000_0000_0000;
         4'h1: rom_data = 32'b0000_0000_0011_1111_1111_1000_0000_0000;
         4'h2: rom_data = 32'b0000_0000_0111_1111_1111_1100_0000_0000;
         4'h3: rom_data = 32'b0000_0000_1111_1100_0111_1110_0000_0000;
         4'h4: rom_data = 32'b0000_0001_1111_1000_0011_1111_0000_0000;
         4'h5: rom_data = 32'b0000_0001_1111_0000_0001_1111_0000_0000;
         4'h6: rom_data = 32'b0000_0011_1111_0000_0000_0000_0000_0000;
         4'h7: rom_data = 32'b0000_0011_1111_0000_0000_0000_0000_0000;
         4'h8: rom_data = 32'b0000_0011_1110_0111_1111_0000_0000_0000;
         4'h9: rom_data = 32'b0000_0011_1111_1111_1111_1110_0000_0000;
         4'hA: rom_data = 32'b0000_0011_1111_1000_0011_1111_0000_0000;
         4'hB: rom_data = 32'b0000_0011_1111_0000_0011_1111_0000_0000;
         4'hC: rom_data = 32'b0000_0001_1111_1000_0011_1111_0000_0000;
         4'hD: rom_data = 32'b0000_0001_1111_1100_0111_1111_0000_0000;
         4'hE: rom_data = 32'b0000_0000_0011_1111_1111_1000_0000_0000;
         4'hF: rom_data = 32'b0000_0000_0001_1111_1111_0000_0000_0000;
         default: rom_data = '0;
      endcase
   end

   // --------------------------------------------------------------------------
   // hit test against the live position
   // --------------------------------------------------------------------------
   assign dx = pix_x - cfg.pos_x;
   assign dy = pix_y - cfg.pos_y;

   // left of the box wraps dx, so check the lower edge too
   assign in_x = (pix_x >= cfg.pos_x) && (dx < `LOGO_W);
   assign in_y = (pix_y >= cfg.pos_y) && (dy < `LOGO_H);

   // low bits are enough once inside the box
   assign rom_row = dy[3:0];
   assign rom_col = dx[4:0];
   assign rom_bit = rom_data[rom_col];

   assign sprite_on = cfg.enable & video_on & in_x & in_y & rom_bit;

endmodule

/* logic/vga_sync_gen.sv */
`timescale 1ns/1ps
`include "logo_display_defines.svh"

module vga_sync_gen (
   input  logic                        clk,
   input  logic                        reset,
   output logo_display_pkg::pix_coord_t pix_x,
   output logo_display_pkg::pix_coord_t pix_y,
   output logic                        hsync,
   output logic                        vsync,
   output logic                        video_on,
   output logic                        refr_tick
);
   import logo_display_pkg::*;

   // sync window edges
   localparam pix_coord_t HS_START = `H_DISPLAY + `H_FRONT;
   localparam pix_coord_t HS_END   = `H_DISPLAY + `H_FRONT + `H_SYNC - 10'd1;
   localparam pix_coord_t VS_START = `V_DISPLAY + `V_FRONT;
   localparam pix_coord_t VS_END   = `V_DISPLAY + `V_FRONT + `V_SYNC - 10'd1;

   // last count of each counter
   localparam pix_coord_t H_LAST = `H_TOTAL - 10'd1;
   localparam pix_coord_t V_LAST = `V_TOTAL - 10'd1;

   pix_coord_t h_count;
   pix_coord_t v_count;
   logic       h_end;
   logic       v_end;

   // --------------------------------------------------------------------------
   // counters
   // --------------------------------------------------------------------------
   assign h_end = (h_count == H_LAST);
   assign v_end = (v_count == V_LAST);

   // pixel clock is clk, step every cycle
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         h_count <= '0;
         v_count <= '0;
      end
      else if (h_end)
      begin
         h_count <= '0;
         // line done, move down or wrap the frame
         if (v_end)
            v_count <= '0;
         else
            v_count <= v_count + 10'd1;
      end
      else
      begin
         h_count <= h_count + 10'd1;
      end
   end

   // --------------------------------------------------------------------------
   // decoded outputs
   // --------------------------------------------------------------------------
   // active low pulses
   assign hsync = ~((h_count >= HS_START) && (h_count <= HS_END));
   assign vsync = ~((v_count >= VS_START) && (v_count <= VS_END));

   // visible area
   assign video_on = (h_count < `H_DISPLAY) && (v_count < `V_DISPLAY);

   // first pixel of first blank line
   assign refr_tick = (h_count == 10'd0) && (v_count == `V_DISPLAY);

   assign pix_x = h_count;
   assign pix_y = v_count;

endmodule

/* logic/wb_sprite_regs.sv */
`timescale 1ns/1ps
`include "logo_display_defines.svh"

module wb_sprite_regs (
   input  logic               clk,
   input  logic               reset,
   input  logic               wb_cyc,
   input  logic               wb_stb,
   input  logic               wb_we,
   input  logic               wb_adr,
   input  logic [31:0]        wb_dat_w,
   output logic [31:0]        wb_dat_r,
   output logic               wb_ack,
   input  logic               refr_tick,
   sprite_cfg_if.source       cfg
);
   import logo_display_pkg::*;

   // shadow copies, written by the host
   pix_coord_t   shadow_x;
   pix_coord_t   shadow_y;
   rgb_t         shadow_rgb;
   logic         shadow_en;

   sprite_word_u wr_word;
   sprite_word_u rd_word;
   logic         wr_en;

   // --------------------------------------------------------------------------
   // bus handshake
   // --------------------------------------------------------------------------
   // one access per request, ack drops after one cycle
   assign wr_en   = wb_cyc & wb_stb & wb_we & ~wb_ack;
   assign wr_word = wb_dat_w;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         wb_ack <= 1'b0;
      else
         wb_ack <= wb_cyc & wb_stb & ~wb_ack;
   end

   // shadow registers
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         shadow_x   <= `POS_X_RESET;
         shadow_y   <= `POS_Y_RESET;
         shadow_rgb <= `STYLE_RGB_RESET;
         shadow_en  <= `STYLE_EN_RESET;
      end
      else if (wr_en)
      begin
         if (wb_adr == `REG_POS)
         begin
            shadow_x <= wr_word.pos.x;
            shadow_y <= wr_word.pos.y;
         end
         else
         begin
            shadow_rgb <= wr_word.style.rgb;
            shadow_en  <= wr_word.style.enable;
         end
      end
   end

   // read-back, reserved fields stay zero
   always_comb
   begin
      rd_word = '0;
      if (wb_adr == `REG_POS)
      begin
         rd_word.pos.x = shadow_x;
         rd_word.pos.y = shadow_y;
      end
      else
      begin
         rd_word.style.rgb    = shadow_rgb;
         rd_word.style.enable = shadow_en;
      end
   end

   assign wb_dat_r = wb_ack ? rd_word.raw : 32'd0;

   // --------------------------------------------------------------------------
   // active copy, frame boundary only
   // --------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         cfg.pos_x  <= `POS_X_RESET;
         cfg.pos_y  <= `POS_Y_RESET;
         cfg.rgb    <= `STYLE_RGB_RESET;
         cfg.enable <= `STYLE_EN_RESET;
      end
      else if (refr_tick)
      begin
         cfg.pos_x  <= shadow_x;
         cfg.pos_y  <= shadow_y;
         cfg.rgb    <= shadow_rgb;
         cfg.enable <= shadow_en;
      end
   end

endmodule

/* logic/sprite_cfg_if.sv */
`timescale 1ns/1ps

// live sprite setup, register block to sprite
interface sprite_cfg_if;
   import logo_display_pkg::*;

   pix_coord_t pos_x;
   pix_coord_t pos_y;
   rgb_t       rgb;
   logic       enable;

   // register side
   modport source (
      output pos_x,
      output pos_y,
      output rgb,
      output enable
   );

   // drawing side
   modport sink (
      input pos_x,
      input pos_y,
      input rgb,
      input enable
   );

endinterface

/* logic/logo_display_pkg.sv */
package logo_display_pkg;

   // screen coordinate, covers both counters
   typedef logic [9:0] pix_coord_t;

   // one bit per gun, red in bit 2
   typedef logic [2:0] rgb_t;

   // ------------------------------------------------------------------------
   // register word views
   // ------------------------------------------------------------------------
   // position word, x low and y high
   typedef struct packed {
      logic [5:0] rsvd_hi;
      pix_coord_t y;
      logic [5:0] rsvd_lo;
      pix_coord_t x;
   } pos_word_t;

   // style word, enable in bit 8
   typedef struct packed {
      logic [22:0] rsvd_hi;
      logic        enable;
      logic [4:0]  rsvd_lo;
      rgb_t        rgb;
   } style_word_t;

   // same 32 bits, picked by address
   typedef union packed {
      pos_word_t   pos;
      style_word_t style;
      logic [31:0] raw;
   } sprite_word_u;

endpackage

/* logic/logo_display_defines.svh */
`ifndef LOGO_DISPLAY_DEFINES_SVH
`define LOGO_DISPLAY_DEFINES_SVH

// --------------------------------------------------------------------------
// vga timing for 640x480, counts in pixel clocks
// --------------------------------------------------------------------------
`define H_DISPLAY 10'd640
`define H_FRONT   10'd16
`define H_SYNC    10'd96
`define H_BACK    10'd48
`define H_TOTAL   (`H_DISPLAY + `H_FRONT + `H_SYNC + `H_BACK)

`define V_DISPLAY 10'd480
`define V_FRONT   10'd10
`define V_SYNC    10'd2
`define V_BACK    10'd33
`define V_TOTAL   (`V_DISPLAY + `V_FRONT + `V_SYNC + `V_BACK)

// glyph box size
`define LOGO_W 10'd32
`define LOGO_H 10'd16

// wishbone word addresses
`define REG_POS   1'b0
`define REG_STYLE 1'b1

// values seen right after reset
`define POS_X_RESET     10'd300
`define POS_Y_RESET     10'd10
`define STYLE_RGB_RESET 3'b101
`define STYLE_EN_RESET  1'b1

`endif
